// File: sources.f
hw/icachePkg.sv
hw/wayRam.sv
hw/lineState.sv
hw/lookupStage.sv
hw/missControl.sv
hw/icacheTop.sv
tests/icacheTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = icacheTb
FILELIST  = sources.f
BUILDDIR  = obj_dir
LOG       = sim.log
PASSTEXT  = Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILDDIR) -o $(TOP)
	./$(BUILDDIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASSTEXT)" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// File: tests/fetchPatterns.txt
// columns: fetch address (hex), flush cycle, expected hit
// flush cycle 0 means none, 1 raises flush in the lookup cycle of that fetch
00001000 0 0
00001004 0 1
00001008 0 1
0000100c 0 1
0003004c 0 0
00030048 0 1
00000050 0 0
00000450 0 0
00000850 0 0
00000c50 0 0
00001050 0 0
00000454 0 1
00000058 0 0
00000c5c 0 1
00002220 1 0
00002220 0 0
00002224 0 1
00002228 1 1
0000105c 0 1

// File: tests/icacheTb.sv
`timescale 1ns/1ps

module icacheTb;
    logic                 clk;
    logic                 rst;
    logic                 fetchValid;
    icachePkg::addrT      fetchPc;
    logic                 flush;
    logic                 memRespValid;
    icachePkg::cacheLineT memRespLine;
    icachePkg::instPairT  fetchOut;
    logic                 stall;
    icachePkg::memReqT    memReq;
    int                   reqCount;
    icachePkg::addrT      playedQ[$];
    icachePkg::addrT      burstQ[$];
    // reference cache state with tags, valid bits and PLRU tree per set
    icachePkg::tagT       refTag   [icachePkg::numSets][icachePkg::numWays];
    logic                 refValid [icachePkg::numSets][icachePkg::numWays];
    icachePkg::plruT      refPlru  [icachePkg::numSets];

    icacheTop i_dut (
        .clk(clk), .rst(rst), .fetchValid(fetchValid), .fetchPc(fetchPc), .flush(flush),
        .memRespValid(memRespValid), .memRespLine(memRespLine),
        .fetchOut(fetchOut), .stall(stall), .memReq(memReq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [15:0] lfsrNext(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic icachePkg::instWordT memWord(icachePkg::addrT wordAddr);
        return wordAddr ^ 32'h5A5A0000;
    endfunction

    function automatic icachePkg::cacheLineT makeLine(icachePkg::addrT lineAddr);
        icachePkg::cacheLineT line;
        for (int i = 0; i < 4; i++) begin
            line[i] = memWord(lineAddr + 32'(4 * i));
        end
        return line;
    endfunction

    function automatic icachePkg::instPairT expectPair(icachePkg::addrT a);
        icachePkg::instPairT p;
        icachePkg::addrT     base;
        base     = {a[31:4], 4'b0000};
        p.pc     = a & ~32'h4;
        p.inst0  = memWord(base + (a[3] ? 32'd8 : 32'd0));
        p.inst1  = memWord(base + (a[3] ? 32'd12 : 32'd4));
        p.valid0 = !a[2];
        p.valid1 = 1'b1;
        return p;
    endfunction

    function automatic int findWay(icachePkg::addrT a);
        int s;
        s = int'(a[icachePkg::offsetBits +: icachePkg::indexBits]);
        for (int w = 0; w < icachePkg::numWays; w++) begin
            if (refValid[s][w] && refTag[s][w] == a[31 -: icachePkg::tagBits]) begin
                return w;
            end
        end
        return -1;
    endfunction

    function automatic int pickVictim(icachePkg::plruT p);
        if (p[0]) begin
            return p[1] ? 0 : 1;
        end
        return p[2] ? 2 : 3;
    endfunction

    // point the tree away from the way just used
    task automatic touchSet(icachePkg::addrT a, int way);
        int s;
        s = int'(a[icachePkg::offsetBits +: icachePkg::indexBits]);
        case (way)
            0: refPlru[s] = {refPlru[s][2], 2'b00};
            1: refPlru[s] = {refPlru[s][2], 2'b10};
            2: refPlru[s] = {1'b0, refPlru[s][1], 1'b1};
            default: refPlru[s] = {1'b1, refPlru[s][1], 1'b1};
        endcase
    endtask

    task automatic fillVictim(icachePkg::addrT a);
        int s;
        int way;
        s   = int'(a[icachePkg::offsetBits +: icachePkg::indexBits]);
        way = pickVictim(refPlru[s]);
        refTag[s][way]   = a[31 -: icachePkg::tagBits];
        refValid[s][way] = 1'b1;
        touchSet(a, way);
    endtask

    task automatic failNow(string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic reportMismatch(string msg);
        failNow($sformatf("Mismatch at %0t: %s", $time, msg));
    endtask

    task automatic checkPair(icachePkg::instPairT got, icachePkg::instPairT exp, string what);
        if (got !== exp) begin
            reportMismatch($sformatf(
                "%s pair pc %h inst %h %h valid %b%b, expected pc %h inst %h %h valid %b%b",
                what, got.pc, got.inst0, got.inst1, got.valid0, got.valid1,
                exp.pc, exp.inst0, exp.inst1, exp.valid0, exp.valid1));
        end
    endtask

    // the address only matters on a real request
    task automatic checkReq(icachePkg::memReqT got, icachePkg::memReqT exp, string what);
        if (got.valid !== exp.valid || (exp.valid && got.addr !== exp.addr)) begin
            reportMismatch($sformatf("%s memReq valid %b addr %h, expected valid %b addr %h",
                what, got.valid, got.addr, exp.valid, exp.addr));
        end
    endtask

    task automatic checkHit(bit got, bit exp, icachePkg::addrT a);
        if (got != exp) begin
            reportMismatch($sformatf("fetch %h hit %b, expected %b", a, got, exp));
        end
    endtask

    task automatic checkLevel(logic got, logic exp, string what);
        if (got !== exp) begin
            reportMismatch($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic checkIdle();
        checkLevel(stall, 1'b0, "stall after reset");
        checkLevel(memReq.valid, 1'b0, "memReq.valid after reset");
        checkLevel(fetchOut.valid0, 1'b0, "valid0 after reset");
        checkLevel(fetchOut.valid1, 1'b0, "valid1 after reset");
    endtask

    task automatic releaseReset();
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int s = 0; s < icachePkg::numSets; s++) begin
            refPlru[s] = '0;
            for (int w = 0; w < icachePkg::numWays; w++) begin
                refValid[s][w] = 1'b0;
            end
        end
        @(negedge clk);
    endtask

    task automatic waitReady();
        int waited;
        waited = 0;
        while (stall) begin
            if (waited >= 50) begin
                failNow("timeout: stall did not fall within 50 cycles");
            end
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic runFetch(icachePkg::addrT a, int flushAt, bit expHit);
        icachePkg::memReqT expReq;
        int reqsBefore;
        int delivered;
        int cyc;
        int respCyc;
        expReq.valid = expHit ? 1'b0 : 1'b1;
        expReq.addr  = {a[31:4], 4'b0000};
        if (flushAt > 1) begin
            failNow("pattern asks for a flush later than the lookup cycle");
        end
        waitReady();
        @(posedge clk);
        #2;
        fetchValid = 1'b1;
        fetchPc    = a;
        flush      = 1'b0;
        reqsBefore = reqCount;
        @(posedge clk);
        #2;
        fetchValid = 1'b0;
        flush      = (flushAt == 1);
        @(negedge clk);
        checkHit(!stall, expHit, a);
        checkReq(memReq, expReq, "lookup");
        if (expHit) begin
            if (flushAt == 0) begin
                checkPair(fetchOut, expectPair(a), "hit");
            end else begin
                checkLevel(fetchOut.valid0 | fetchOut.valid1, 1'b0, "flushed hit valid");
            end
            touchSet(a, findWay(a));
        end else begin
            checkLevel(fetchOut.valid1, 1'b0, "valid1 in the request cycle");
            delivered = 0;
            cyc       = 1;
            respCyc   = -10;
            while (stall) begin
                if (cyc >= 50) begin
                    failNow("timeout: stall stayed high for 50 cycles after a miss");
                end
                @(posedge clk);
                #2;
                flush = 1'b0;
                @(negedge clk);
                cyc++;
                checkLevel(memReq.valid, 1'b0, "memReq.valid while the miss is open");
                if (memRespValid) begin
                    respCyc = cyc;
                end
                if (fetchOut.valid0 || fetchOut.valid1) begin
                    delivered++;
                    checkLevel(memRespValid, 1'b1, "response strobe at delivery");
                    checkLevel(stall, 1'b1, "stall in the refill cycle");
                    checkPair(fetchOut, expectPair(a), "refill");
                end
            end
            if (cyc != respCyc + 1) begin
                failNow("stall did not fall in the cycle after the memory response");
            end
            if (delivered != ((flushAt == 0) ? 1 : 0) || reqCount - reqsBefore != 1) begin
                failNow($sformatf("miss at %h gave %0d pairs and %0d requests",
                    a, delivered, reqCount - reqsBefore));
            end
            if (flushAt == 0) begin
                fillVictim(a);
            end
        end
    endtask

    // one strobe per cycle with each pair one cycle behind its fetch
    task automatic runBurst();
        waitReady();
        @(posedge clk);
        #2;
        fetchValid = 1'b1;
        fetchPc    = burstQ[0];
        flush      = 1'b0;
        for (int i = 1; i <= burstQ.size(); i++) begin
            @(posedge clk);
            #2;
            if (i < burstQ.size()) begin
                fetchPc = burstQ[i];
            end else begin
                fetchValid = 1'b0;
            end
            @(negedge clk);
            checkHit(!stall, 1'b1, burstQ[i-1]);
            checkPair(fetchOut, expectPair(burstQ[i-1]), "back-to-back hit");
            touchSet(burstQ[i-1], findWay(burstQ[i-1]));
        end
    endtask

    // memory answers each request after 1 to 4 cycles
    initial begin : memModel
        logic [15:0]     lfsr;
        logic [1:0]      pick;
        icachePkg::addrT lineAddr;
        memRespValid = 1'b0;
        memRespLine  = '0;
        reqCount     = 0;
        lfsr         = 16'd43;
        forever begin
            @(negedge clk);
            if (memReq.valid) begin
                reqCount++;
                lineAddr = memReq.addr;
                pick[0]  = lfsr[0];
                lfsr     = lfsrNext(lfsr);
                pick[1]  = lfsr[0];
                lfsr     = lfsrNext(lfsr);
                repeat (1 + int'(pick)) @(posedge clk);
                #2;
                memRespValid = 1'b1;
                memRespLine  = makeLine(lineAddr);
                @(posedge clk);
                #2;
                memRespValid = 1'b0;
            end
        end
    end

    initial begin : mainFlow
        int              fd;
        int              code;
        string           line;
        icachePkg::addrT addr;
        int              flushAt;
        int              expHit;
        rst        = 1'b1;
        fetchValid = 1'b0;
        fetchPc    = '0;
        flush      = 1'b0;
        releaseReset();
        checkIdle();
        fd = $fopen("tests/fetchPatterns.txt", "r");
        if (fd == 0) begin
            failNow("could not open tests/fetchPatterns.txt");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code != 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
                if ($sscanf(line, "%h %d %d", addr, flushAt, expHit) != 3) begin
                    failNow({"could not parse pattern line: ", line});
                end
                if ((findWay(addr) >= 0) != (expHit != 0)) begin
                    failNow($sformatf("hit flag for %h disagrees with the PLRU model", addr));
                end
                runFetch(addr, flushAt, expHit != 0);
                playedQ.push_back(addr);
            end
        end
        $fclose(fd);
        foreach (playedQ[i]) begin
            if (findWay(playedQ[i]) >= 0 && burstQ.size() < 8) begin
                burstQ.push_back(playedQ[i]);
            end
        end
        if (burstQ.size() < 2) begin
            failNow("too few resident lines for the back-to-back run");
        end
        runBurst();
        // second reset empties every set again
        @(posedge clk);
        #2;
        rst = 1'b1;
        releaseReset();
        checkIdle();
        runFetch(burstQ[0], 0, findWay(burstQ[0]) >= 0);
        runFetch(burstQ[0], 0, findWay(burstQ[0]) >= 0);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: hw/icacheTop.sv
`timescale 1ns/1ps

module icacheTop (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fetchValid,
    input  icachePkg::addrT       fetchPc,
    input  logic                  flush,
    input  logic                  memRespValid,
    input  icachePkg::cacheLineT  memRespLine,
    output icachePkg::instPairT   fetchOut,
    output logic                  stall,
    output icachePkg::memReqT     memReq
);
    icachePkg::setIndexT                       ramIndex;
    icachePkg::tagT                            heldTag;
    icachePkg::addrT                           heldAddr;
    icachePkg::tagT [icachePkg::numWays-1:0]       wayTags;
    icachePkg::cacheLineT [icachePkg::numWays-1:0] wayLines;
    icachePkg::wayMaskT                        validBits;
    icachePkg::wayMaskT                        wayWrite;
    icachePkg::wayMaskT                        hitMask;
    logic                                      hit;
    logic                                      lookupValid;
    logic                                      refillEn;

    for (genvar w = 0; w < icachePkg::numWays; w++) begin : gWay
        wayRam wayInst (
            .clk     (clk),
            .index   (ramIndex),
            .writeEn (wayWrite[w]),
            .tagIn   (heldTag),
            .lineIn  (memRespLine),
            .tagOut  (wayTags[w]),
            .lineOut (wayLines[w])
        );
    end

    lineState stateInst (
        .clk         (clk),
        .rst         (rst),
        .setIndex    (heldAddr[icachePkg::offsetBits +: icachePkg::indexBits]),
        .lookupValid (lookupValid),
        .hitMask     (hitMask),
        .refillEn    (refillEn),
        .validBits   (validBits),
        .wayWrite    (wayWrite)
    );

    lookupStage lookupInst (
        .clk         (clk),
        .rst         (rst),
        .fetchValid  (fetchValid),
        .fetchPc     (fetchPc),
        .flush       (flush),
        .stall       (stall),
        .wayTags     (wayTags),
        .wayLines    (wayLines),
        .validBits   (validBits),
        .memRespLine (memRespLine),
        .refillEn    (refillEn),
        .ramIndex    (ramIndex),
        .heldTag     (heldTag),
        .heldAddr    (heldAddr),
        .hitMask     (hitMask),
        .hit         (hit),
        .lookupValid (lookupValid),
        .fetchOut    (fetchOut)
    );

    missControl missInst (
        .clk          (clk),
        .rst          (rst),
        .lookupValid  (lookupValid),
        .hit          (hit),
        .flush        (flush),
        .heldAddr     (heldAddr),
        .memRespValid (memRespValid),
        .stall        (stall),
        .memReq       (memReq),
        .refillEn     (refillEn)
    );

endmodule

// File: hw/missControl.sv
`timescale 1ns/1ps

module missControl (
    input  logic                clk,
    input  logic                rst,
    input  logic                lookupValid,
    input  logic                hit,
    input  logic                flush,
    input  icachePkg::addrT     heldAddr,
    input  logic                memRespValid,
    output logic                stall,
    output icachePkg::memReqT   memReq,
    output logic                refillEn
);
    icachePkg::missStateT state;
    icachePkg::missStateT nextState;
    logic                 missNow;

    assign missNow = (state == icachePkg::sRunning) && lookupValid && !hit;

    always_comb begin
        nextState = state;
        case (state)
            icachePkg::sRunning: begin
                if (missNow) begin
                    nextState = flush ? icachePkg::sRecover : icachePkg::sBlock;
                end
            end
            icachePkg::sBlock: begin
                // response wins over a flush in the same cycle
                if (memRespValid) begin
                    nextState = icachePkg::sRunning;
                end else if (flush) begin
                    nextState = icachePkg::sRecover;
                end
            end
            icachePkg::sRecover: begin
                // drop the line without a write
                if (memRespValid) begin
                    nextState = icachePkg::sRunning;
                end
            end
            default: begin
                nextState = icachePkg::sRunning;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= icachePkg::sRunning;
        end else begin
            state <= nextState;
        end
    end

    // stall holds through the response cycle
    assign stall    = (state != icachePkg::sRunning) || missNow;
    assign refillEn = (state == icachePkg::sBlock) && memRespValid;

    always_comb begin
        memReq.valid = missNow;
        memReq.addr  = {heldAddr[31:icachePkg::offsetBits], {icachePkg::offsetBits{1'b0}}};
    end

    // memory only answers an open request
    assert property (@(posedge clk) disable iff (rst)
        memRespValid |-> state != icachePkg::sRunning);

endmodule

// File: hw/lookupStage.sv
`timescale 1ns/1ps

module lookupStage (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      fetchValid,
    input  icachePkg::addrT                           fetchPc,
    input  logic                                      flush,
    input  logic                                      stall,
    input  icachePkg::tagT [icachePkg::numWays-1:0]       wayTags,
    input  icachePkg::cacheLineT [icachePkg::numWays-1:0] wayLines,
    input  icachePkg::wayMaskT                        validBits,
    input  icachePkg::cacheLineT                      memRespLine,
    input  logic                                      refillEn,
    output icachePkg::setIndexT                       ramIndex,
    output icachePkg::tagT                            heldTag,
    output icachePkg::addrT                           heldAddr,
    output icachePkg::wayMaskT                        hitMask,
    output logic                                      hit,
    output logic                                      lookupValid,
    output icachePkg::instPairT                       fetchOut
);
    logic                 heldValid;
    logic                 deliver;
    icachePkg::cacheLineT hitLine;
    icachePkg::cacheLineT srcLine;

    // the refill cycle retires the held lookup
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            heldValid <= 1'b0;
        end else if (!stall) begin
            heldValid <= fetchValid;
        end else if (refillEn) begin
            heldValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && fetchValid) begin
            heldAddr <= fetchPc;
        end
    end

    assign ramIndex = stall ? heldAddr[icachePkg::offsetBits +: icachePkg::indexBits]
                            : fetchPc[icachePkg::offsetBits +: icachePkg::indexBits];
    assign heldTag     = heldAddr[31 -: icachePkg::tagBits];
    assign lookupValid = heldValid;

    always_comb begin
        hitLine = '0;
        for (int w = 0; w < icachePkg::numWays; w++) begin
            hitMask[w] = validBits[w] && (wayTags[w] == heldTag);
            if (hitMask[w]) begin
                hitLine = hitLine | wayLines[w];
            end
        end
    end

    assign hit     = heldValid && |hitMask;
    assign srcLine = refillEn ? memRespLine : hitLine;
    assign deliver = (hit || refillEn) && !flush;

    always_comb begin
        fetchOut.pc     = {heldAddr[31:3], 1'b0, heldAddr[1:0]};
        fetchOut.inst0  = srcLine[{heldAddr[3], 1'b0}];
        fetchOut.inst1  = srcLine[{heldAddr[3], 1'b1}];
        // odd word fetch only carries the second slot
        fetchOut.valid0 = deliver && !heldAddr[2];
        fetchOut.valid1 = deliver;
    end

    // a tag lives in at most one way of a set
    assert property (@(posedge clk) disable iff (rst) $onehot0(hitMask));

endmodule

// File: hw/lineState.sv
`timescale 1ns/1ps

module lineState (
    input  logic                 clk,
    input  logic                 rst,
    input  icachePkg::setIndexT  setIndex,
    input  logic                 lookupValid,
    input  icachePkg::wayMaskT   hitMask,
    input  logic                 refillEn,
    output icachePkg::wayMaskT   validBits,
    output icachePkg::wayMaskT   wayWrite
);
    icachePkg::wayMaskT validMem [icachePkg::numSets];
    icachePkg::plruT    plruMem  [icachePkg::numSets];
    icachePkg::plruT    curPlru;
    icachePkg::wayMaskT victim;
    icachePkg::wayMaskT usedWay;
    logic               touchEn;

    // turn the tree away from the way just used
    function automatic icachePkg::plruT touch(
        input icachePkg::plruT    cur,
        input icachePkg::wayMaskT way
    );
        icachePkg::plruT nxt;
        nxt = cur;
        if (way[0]) begin
            nxt[0] = 1'b0;
            nxt[1] = 1'b0;
        end else if (way[1]) begin
            nxt[0] = 1'b0;
            nxt[1] = 1'b1;
        end else if (way[2]) begin
            nxt[0] = 1'b1;
            nxt[2] = 1'b0;
        end else if (way[3]) begin
            nxt[0] = 1'b1;
            nxt[2] = 1'b1;
        end
        return nxt;
    endfunction

    assign curPlru   = plruMem[setIndex];
    assign validBits = validMem[setIndex];

    always_comb begin
        if (curPlru[0]) begin
            victim = curPlru[1] ? 4'b0001 : 4'b0010;
        end else begin
            victim = curPlru[2] ? 4'b0100 : 4'b1000;
        end
    end

    assign wayWrite = refillEn ? victim : '0;
    assign usedWay  = refillEn ? victim : hitMask;
    assign touchEn  = refillEn || (lookupValid && |hitMask);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < icachePkg::numSets; s++) begin
                validMem[s] <= '0;
                plruMem[s]  <= '0;
            end
        end else begin
            if (touchEn) begin
                plruMem[setIndex] <= touch(curPlru, usedWay);
            end
            if (refillEn) begin
                validMem[setIndex] <= validMem[setIndex] | victim;
            end
        end
    end

    // a refill never lands in a set that already holds the tag
    assert property (@(posedge clk) disable iff (rst) refillEn |-> hitMask == '0);

endmodule

// File: hw/wayRam.sv
`timescale 1ns/1ps

module wayRam (
    input  logic                  clk,
    input  icachePkg::setIndexT   index,
    input  logic                  writeEn,
    input  icachePkg::tagT        tagIn,
    input  icachePkg::cacheLineT  lineIn,
    output icachePkg::tagT        tagOut,
    output icachePkg::cacheLineT  lineOut
);
    icachePkg::tagT       tagMem  [icachePkg::numSets];
    icachePkg::cacheLineT lineMem [icachePkg::numSets];

    // single port, read-first
    always_ff @(posedge clk) begin
        if (writeEn) begin
            tagMem[index] <= tagIn;
        end
        tagOut <= tagMem[index];
    end

    always_ff @(posedge clk) begin
        if (writeEn) begin
            lineMem[index] <= lineIn;
        end
        lineOut <= lineMem[index];
    end

endmodule

// File: hw/icachePkg.sv
package icachePkg;

    // geometry
    localparam int numWays    = 4;
    localparam int numSets    = 64;
    localparam int lineBits   = 128;
    localparam int indexBits  = 6;
    localparam int tagBits    = 22;
    localparam int offsetBits = 4;

    typedef logic [31:0] addrT;
    typedef logic [tagBits-1:0] tagT;
    typedef logic [indexBits-1:0] setIndexT;
    typedef logic [31:0] instWordT;

    // word 0 sits in the low bits
    typedef instWordT [lineBits/32-1:0] cacheLineT;

    typedef logic [numWays-1:0] wayMaskT;

    // bit 0 picks a half, bit 1 inside ways 0/1, bit 2 inside ways 2/3
    typedef logic [2:0] plruT;

    // second slot pc is pc + 4 and is not stored
    typedef struct packed {
        addrT     pc;
        instWordT inst0;
        instWordT inst1;
        logic     valid0;
        logic     valid1;
    } instPairT;

    typedef struct packed {
        logic valid;
        addrT addr;
    } memReqT;

    typedef enum logic [1:0] {
        sRunning,
        sBlock,
        sRecover
    } missStateT;

endpackage
